// File: Bender.yml
package:
  name: flash_programmer

sources:
  - include_dirs:
      - .
    files:
      - hdl/flash_prog_pkg.sv
      - hdl/prog_sequencer.sv
      - hdl/frame_engine.sv
      - hdl/response_capture.sv
      - hdl/flash_programmer.sv
  - target: test
    include_dirs:
      - .
      - testbench
    files:
      - testbench/tb_flash_programmer.sv

// File: flash_prog_settings.svh
`ifndef FLASH_PROG_SETTINGS_SVH
`define FLASH_PROG_SETTINGS_SVH

// Startup delay is 2**STARTUP_LOG2 clock cycles
`define STARTUP_LOG2    5

// Flash address used by erase, page program and readback
`define SECTOR_ADDR     24'hFE0000

`define PAGE_BYTES      4       // Bytes programmed and read back
`define ADDR_BYTES      3       // Address bytes per frame

// Status register bit positions
`define STATUS_WIP_BIT  0
`define STATUS_WEL_BIT  1

// Manufacturer, memory type, capacity
`define EXPECTED_ID     24'hC22817

`endif

// File: hdl/flash_prog_pkg.sv
package flash_prog_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Flash opcodes, single SPI mode only
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [7:0] {
        READ = 8'h03,
        PP   = 8'h02,
        SE   = 8'h20,   // 4 KB sector erase
        WREN = 8'h06,
        WRDI = 8'h04,
        RDSR = 8'h05,
        RDID = 8'h9F
    } flash_opcode_e;

    // Programming sequence, in execution order
    typedef enum logic [3:0] {
        ST_STARTUP,
        ST_READ_ID,
        ST_SET_WEL,
        ST_POLL_WEL_SET,
        ST_ERASE,
        ST_POLL_ERASE,
        ST_SET_WEL2,
        ST_POLL_WEL2,
        ST_PAGE_PROG,
        ST_POLL_PROG,
        ST_RESET_WEL,
        ST_POLL_WEL_CLR,
        ST_READ_BACK,
        ST_DONE,
        ST_ERROR
    } prog_state_e;

    typedef enum logic [2:0] {
        FR_IDLE,
        FR_CMD,
        FR_ADDR,
        FR_WRITE,
        FR_READ
    } frame_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles between blocks
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic          start;   // One-cycle pulse
        flash_opcode_e opcode;
        logic [23:0]   addr;
    } frame_cmd_t;

    typedef struct packed {
        logic       en;
        logic [7:0] tx_byte;
    } spi_byte_req_t;

    typedef struct packed {
        logic       done;
        logic [7:0] rx_byte;
    } spi_byte_rsp_t;

    // One byte of the response phase
    typedef struct packed {
        logic       valid;
        logic [2:0] index;
        logic [7:0] data;
    } rsp_byte_t;

endpackage

// File: hdl/flash_programmer.sv
module flash_programmer (
    input  logic                          clk,
    input  logic                          rst_n,
    output flash_prog_pkg::spi_byte_req_t spi_req,
    input  flash_prog_pkg::spi_byte_rsp_t spi_rsp,
    output logic                          frame_active,
    output logic                          data_req,
    input  logic [7:0]                    prog_data,
    output logic [23:0]                   flash_id,
    output logic [7:0]                    rd_data,
    output logic                          rd_valid,
    output logic                          done,
    output logic                          error
);

    flash_prog_pkg::frame_cmd_t frame_cmd;
    flash_prog_pkg::rsp_byte_t  rsp_byte;
    logic                       frame_done;
    logic                       status_fresh;
    logic                       wel;
    logic                       wip;
    logic                       id_match;

    prog_sequencer u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_done   (frame_done),
        .status_fresh (status_fresh),
        .wel          (wel),
        .wip          (wip),
        .id_match     (id_match),
        .frame_cmd    (frame_cmd),
        .done         (done),
        .error        (error)
    );

    frame_engine u_frame (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_cmd    (frame_cmd),
        .spi_req      (spi_req),
        .spi_rsp      (spi_rsp),
        .prog_data    (prog_data),
        .data_req     (data_req),
        .frame_active (frame_active),
        .frame_done   (frame_done),
        .rsp_byte     (rsp_byte)
    );

    response_capture u_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_cmd    (frame_cmd),
        .rsp_byte     (rsp_byte),
        .flash_id     (flash_id),
        .id_match     (id_match),
        .status_fresh (status_fresh),
        .wel          (wel),
        .wip          (wip),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

endmodule

// File: hdl/frame_engine.sv
`include "flash_prog_settings.svh"

module frame_engine (
    input  logic                          clk,
    input  logic                          rst_n,
    input  flash_prog_pkg::frame_cmd_t    frame_cmd,
    output flash_prog_pkg::spi_byte_req_t spi_req,
    input  flash_prog_pkg::spi_byte_rsp_t spi_rsp,
    input  logic [7:0]                    prog_data,
    output logic                          data_req,
    output logic                          frame_active,
    output logic                          frame_done,
    output flash_prog_pkg::rsp_byte_t     rsp_byte
);

    flash_prog_pkg::frame_state_e  state;
    flash_prog_pkg::frame_state_e  phase_nxt;
    flash_prog_pkg::flash_opcode_e cur_op;
    logic [23:0] cur_addr;
    logic [2:0]  n_addr;
    logic [2:0]  n_write;
    logic [2:0]  n_read;
    logic [2:0]  phase_len;
    logic [2:0]  byte_cnt;
    logic        phase_last;
    logic        pending;       // Enable sent, done not yet seen
    logic        issue;
    logic        xfer_done;
    logic        req_en;
    logic [7:0]  req_tx;
    logic [7:0]  tx_byte;

    ////////////////////////////////////////////////////////////////////////////
    // Frame shape per opcode
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        n_addr  = 3'd0;
        n_write = 3'd0;
        n_read  = 3'd0;
        case (cur_op)
            flash_prog_pkg::RDID: n_read = 3'd3;
            flash_prog_pkg::RDSR: n_read = 3'd1;
            flash_prog_pkg::SE:   n_addr = 3'(`ADDR_BYTES);
            flash_prog_pkg::PP: begin
                n_addr  = 3'(`ADDR_BYTES);
                n_write = 3'(`PAGE_BYTES);
            end
            flash_prog_pkg::READ: begin
                n_addr = 3'(`ADDR_BYTES);
                n_read = 3'(`PAGE_BYTES);
            end
            default: ;      // WREN, WRDI are opcode only
        endcase
    end

    always_comb begin
        case (state)
            flash_prog_pkg::FR_ADDR:  phase_len = n_addr;
            flash_prog_pkg::FR_WRITE: phase_len = n_write;
            flash_prog_pkg::FR_READ:  phase_len = n_read;
            default:                  phase_len = 3'd1;
        endcase
        phase_nxt = flash_prog_pkg::FR_IDLE;
        if (state == flash_prog_pkg::FR_CMD && n_addr != 3'd0) begin
            phase_nxt = flash_prog_pkg::FR_ADDR;
        end else if (state inside {flash_prog_pkg::FR_CMD, flash_prog_pkg::FR_ADDR}) begin
            if (n_write != 3'd0) begin
                phase_nxt = flash_prog_pkg::FR_WRITE;
            end else if (n_read != 3'd0) begin
                phase_nxt = flash_prog_pkg::FR_READ;
            end
        end
    end

    assign phase_last = (byte_cnt == phase_len - 3'd1);
    assign issue      = (state != flash_prog_pkg::FR_IDLE) && !pending;
    assign xfer_done  = pending && spi_rsp.done;

    always_comb begin
        case (state)
            flash_prog_pkg::FR_ADDR:  tx_byte = cur_addr[23:16];  // MSB first
            flash_prog_pkg::FR_WRITE: tx_byte = prog_data;
            default:                  tx_byte = 8'h00;            // Dummy for reads
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= flash_prog_pkg::FR_IDLE;
            pending      <= 1'b0;
            byte_cnt     <= 3'd0;
            req_en       <= 1'b0;
            data_req     <= 1'b0;
            frame_active <= 1'b0;
            frame_done   <= 1'b0;
        end else begin
            req_en     <= 1'b0;
            data_req   <= 1'b0;
            frame_done <= 1'b0;
            if (state == flash_prog_pkg::FR_IDLE) begin
                if (frame_cmd.start) begin     // Opcode goes out right away
                    state        <= flash_prog_pkg::FR_CMD;
                    byte_cnt     <= 3'd0;
                    req_en       <= 1'b1;
                    pending      <= 1'b1;
                    frame_active <= 1'b1;
                end
            end else if (xfer_done) begin
                pending <= 1'b0;
                if (phase_last) begin
                    state    <= phase_nxt;
                    byte_cnt <= 3'd0;
                    if (phase_nxt == flash_prog_pkg::FR_IDLE) begin
                        frame_active <= 1'b0;
                        frame_done   <= 1'b1;
                    end
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end else if (issue) begin
                req_en   <= 1'b1;
                pending  <= 1'b1;
                data_req <= (state == flash_prog_pkg::FR_WRITE);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == flash_prog_pkg::FR_IDLE && frame_cmd.start) begin
            cur_op   <= frame_cmd.opcode;
            cur_addr <= frame_cmd.addr;
            req_tx   <= frame_cmd.opcode;
        end else if (issue) begin
            req_tx <= tx_byte;
            if (state == flash_prog_pkg::FR_ADDR) begin
                cur_addr <= {cur_addr[15:0], 8'h00};
            end
        end
    end

    assign spi_req  = '{en: req_en, tx_byte: req_tx};
    assign rsp_byte = '{valid: xfer_done && state == flash_prog_pkg::FR_READ,
                        index: byte_cnt,
                        data:  spi_rsp.rx_byte};

    // One byte in flight at a time
    assert property (@(posedge clk) disable iff (!rst_n)
        req_en |=> !req_en until_with spi_rsp.done);

    assert property (@(posedge clk) disable iff (!rst_n) req_en |-> frame_active);

endmodule

// File: hdl/prog_sequencer.sv
`include "flash_prog_settings.svh"

module prog_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       frame_done,
    input  logic                       status_fresh,
    input  logic                       wel,
    input  logic                       wip,
    input  logic                       id_match,
    output flash_prog_pkg::frame_cmd_t frame_cmd,
    output logic                       done,
    output logic                       error
);

    flash_prog_pkg::prog_state_e   state;
    flash_prog_pkg::prog_state_e   state_nxt;
    flash_prog_pkg::flash_opcode_e cmd_op;
    logic                          cmd_start;
    logic                          launch;
    logic                          reissue;
    logic                          is_poll;
    logic                          status_ok;
    logic [`STARTUP_LOG2:0]        startup_cnt;

    // Opcode of the frame issued in each state
    function automatic flash_prog_pkg::flash_opcode_e state_op(
        input flash_prog_pkg::prog_state_e s
    );
        flash_prog_pkg::flash_opcode_e op;
        case (s)
            flash_prog_pkg::ST_READ_ID:   op = flash_prog_pkg::RDID;
            flash_prog_pkg::ST_SET_WEL:   op = flash_prog_pkg::WREN;
            flash_prog_pkg::ST_SET_WEL2:  op = flash_prog_pkg::WREN;
            flash_prog_pkg::ST_ERASE:     op = flash_prog_pkg::SE;
            flash_prog_pkg::ST_PAGE_PROG: op = flash_prog_pkg::PP;
            flash_prog_pkg::ST_RESET_WEL: op = flash_prog_pkg::WRDI;
            flash_prog_pkg::ST_READ_BACK: op = flash_prog_pkg::READ;
            default:                      op = flash_prog_pkg::RDSR; // Poll states
        endcase
        return op;
    endfunction

    // Free-running until the top bit sets, then holds
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            startup_cnt <= '0;
        end else if (!startup_cnt[`STARTUP_LOG2]) begin
            startup_cnt <= startup_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Poll conditions
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        is_poll   = 1'b0;
        status_ok = 1'b0;
        case (state)
            flash_prog_pkg::ST_POLL_WEL_SET, flash_prog_pkg::ST_POLL_WEL2: begin
                is_poll   = 1'b1;
                status_ok = wel;
            end
            flash_prog_pkg::ST_POLL_ERASE, flash_prog_pkg::ST_POLL_PROG: begin
                is_poll   = 1'b1;
                status_ok = !wip;
            end
            flash_prog_pkg::ST_POLL_WEL_CLR: begin
                is_poll   = 1'b1;
                status_ok = !wel;
            end
            default: ;
        endcase
    end

    // States run in enum order, so most steps are state + 1
    always_comb begin
        state_nxt = state;
        reissue   = 1'b0;
        case (state)
            flash_prog_pkg::ST_STARTUP: begin
                if (startup_cnt[`STARTUP_LOG2]) begin
                    state_nxt = flash_prog_pkg::ST_READ_ID;
                end
            end
            flash_prog_pkg::ST_READ_ID: begin
                if (frame_done) begin
                    state_nxt = id_match ? flash_prog_pkg::ST_SET_WEL
                                         : flash_prog_pkg::ST_ERROR;
                end
            end
            flash_prog_pkg::ST_DONE, flash_prog_pkg::ST_ERROR: ;   // Terminal
            default: begin
                if (is_poll) begin
                    if (status_fresh && status_ok) begin
                        state_nxt = flash_prog_pkg::prog_state_e'(state + 4'd1);
                    end else if (status_fresh) begin
                        reissue = 1'b1;     // Another RDSR
                    end
                end else if (frame_done) begin
                    state_nxt = flash_prog_pkg::prog_state_e'(state + 4'd1);
                end
            end
        endcase
        launch = reissue || (state_nxt != state &&
                             state_nxt != flash_prog_pkg::ST_DONE &&
                             state_nxt != flash_prog_pkg::ST_ERROR);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= flash_prog_pkg::ST_STARTUP;
            cmd_start <= 1'b0;
        end else begin
            state     <= state_nxt;
            cmd_start <= launch;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            cmd_op <= state_op(state_nxt);
        end
    end

    assign frame_cmd = '{start: cmd_start, opcode: cmd_op, addr: `SECTOR_ADDR};
    assign done      = (state == flash_prog_pkg::ST_DONE);
    assign error     = (state == flash_prog_pkg::ST_ERROR);

    // Frame engine needs an idle cycle between commands
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_cmd.start |=> !frame_cmd.start);

endmodule

// File: hdl/response_capture.sv
`include "flash_prog_settings.svh"

module response_capture (
    input  logic                       clk,
    input  logic                       rst_n,
    input  flash_prog_pkg::frame_cmd_t frame_cmd,
    input  flash_prog_pkg::rsp_byte_t  rsp_byte,
    output logic [23:0]                flash_id,
    output logic                       id_match,
    output logic                       status_fresh,
    output logic                       wel,
    output logic                       wip,
    output logic                       rd_valid,
    output logic [7:0]                 rd_data
);

    flash_prog_pkg::flash_opcode_e cur_op;

    // Opcode of the frame in progress
    always_ff @(posedge clk) begin
        if (frame_cmd.start) begin
            cur_op <= frame_cmd.opcode;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Route response bytes by opcode
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flash_id     <= 24'h0;
            status_fresh <= 1'b0;
            wel          <= 1'b0;
            wip          <= 1'b0;
            rd_valid     <= 1'b0;
        end else begin
            status_fresh <= 1'b0;
            rd_valid     <= 1'b0;
            if (rsp_byte.valid) begin
                case (cur_op)
                    flash_prog_pkg::RDID: begin
                        case (rsp_byte.index)   // Manufacturer byte first
                            3'd0:    flash_id[23:16] <= rsp_byte.data;
                            3'd1:    flash_id[15:8]  <= rsp_byte.data;
                            default: flash_id[7:0]   <= rsp_byte.data;
                        endcase
                    end
                    flash_prog_pkg::RDSR: begin
                        wel          <= rsp_byte.data[`STATUS_WEL_BIT];
                        wip          <= rsp_byte.data[`STATUS_WIP_BIT];
                        status_fresh <= 1'b1;
                    end
                    flash_prog_pkg::READ: rd_valid <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_byte.valid) begin
            rd_data <= rsp_byte.data;
        end
    end

    // Valid in the frame_done cycle of RDID
    assign id_match = (flash_id == `EXPECTED_ID);

endmodule

// File: tb.f
+incdir+.
+incdir+testbench
hdl/flash_prog_pkg.sv
hdl/prog_sequencer.sv
hdl/frame_engine.sv
hdl/response_capture.sv
hdl/flash_programmer.sv
testbench/tb_flash_programmer.sv

// File: testbench/tb_flash_table.svh
`ifndef TB_FLASH_TABLE_SVH
`define TB_FLASH_TABLE_SVH

// Columns: tx is the byte the DUT must send, rx is the byte the serializer
// returns, eof marks the last transfer of a frame
typedef struct packed {
    logic [7:0] tx;
    logic [7:0] rx;
    logic       eof;
} xfer_row_t;

localparam int GOOD_FIRST = 0;
localparam int GOOD_ROWS  = 57;
localparam int BAD_FIRST  = 57;
localparam int BAD_ROWS   = 4;
localparam int ID_ROWS    = 4;      // Opcode plus three ID bytes

localparam logic [7:0] ADDR_HI  = 8'(`SECTOR_ADDR >> 16);
localparam logic [7:0] ADDR_MID = 8'(`SECTOR_ADDR >> 8);
localparam logic [7:0] ADDR_LO  = 8'(`SECTOR_ADDR);
localparam logic [7:0] ID_HI    = 8'(`EXPECTED_ID >> 16);
localparam logic [7:0] ID_MID   = 8'(`EXPECTED_ID >> 8);
localparam logic [7:0] ID_LO    = 8'(`EXPECTED_ID);

localparam logic [7:0] PAGE_DATA [`PAGE_BYTES] = '{8'hA5, 8'h3C, 8'h5A, 8'hC3};

localparam xfer_row_t XFER_TABLE [GOOD_ROWS + BAD_ROWS] = '{
    // Read ID
    '{8'h9F, 8'hFF, 1'b0}, '{8'h00, ID_HI, 1'b0}, '{8'h00, ID_MID, 1'b0}, '{8'h00, ID_LO, 1'b1},
    '{8'h06, 8'hFF, 1'b1},                                  // WREN
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h00, 1'b1}, '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h00, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h02, 1'b1},           // WEL finally set
    // Sector erase and busy poll
    '{8'h20, 8'hFF, 1'b0}, '{ADDR_HI, 8'hFF, 1'b0}, '{ADDR_MID, 8'hFF, 1'b0},
    '{ADDR_LO, 8'hFF, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h03, 1'b1}, '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h03, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h00, 1'b1},
    '{8'h06, 8'hFF, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h00, 1'b1}, '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h00, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h02, 1'b1},
    // Page program
    '{8'h02, 8'hFF, 1'b0}, '{ADDR_HI, 8'hFF, 1'b0}, '{ADDR_MID, 8'hFF, 1'b0},
    '{ADDR_LO, 8'hFF, 1'b0},
    '{PAGE_DATA[0], 8'hFF, 1'b0}, '{PAGE_DATA[1], 8'hFF, 1'b0},
    '{PAGE_DATA[2], 8'hFF, 1'b0}, '{PAGE_DATA[3], 8'hFF, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h03, 1'b1}, '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h03, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h00, 1'b1},
    '{8'h04, 8'hFF, 1'b1},                                  // WRDI
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h02, 1'b1}, '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h02, 1'b1},
    '{8'h05, 8'hFF, 1'b0}, '{8'h00, 8'h00, 1'b1},
    // Readback, dummy bytes out
    '{8'h03, 8'hFF, 1'b0}, '{ADDR_HI, 8'hFF, 1'b0}, '{ADDR_MID, 8'hFF, 1'b0},
    '{ADDR_LO, 8'hFF, 1'b0},
    '{8'h00, PAGE_DATA[0], 1'b0}, '{8'h00, PAGE_DATA[1], 1'b0},
    '{8'h00, PAGE_DATA[2], 1'b0}, '{8'h00, PAGE_DATA[3], 1'b1},
    // Second run, last ID byte is off by one
    '{8'h9F, 8'hFF, 1'b0}, '{8'h00, ID_HI, 1'b0}, '{8'h00, ID_MID, 1'b0},
    '{8'h00, ID_LO ^ 8'h01, 1'b1}
};

`endif

// File: testbench/tb_flash_programmer.sv
`include "flash_prog_settings.svh"

module tb_flash_programmer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT   = 400;      // Per wait loop
    localparam int QUIET_CYCLES = 100;      // Window with no traffic after error

    `include "tb_flash_table.svh"

    logic                          clk = 1'b0;
    logic                          rst_n;
    flash_prog_pkg::spi_byte_req_t spi_req;
    flash_prog_pkg::spi_byte_rsp_t spi_rsp;
    logic                          frame_active;
    logic                          data_req;
    logic [7:0]                    prog_data;
    logic [23:0]                   flash_id;
    logic [7:0]                    rd_data;
    logic                          rd_valid;
    logic                          done;
    logic                          error;
    integer                        seed;
    int                            wr_cnt;
    int                            rd_cnt;
    string                         test_name;

    flash_programmer dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .spi_req      (spi_req),
        .spi_rsp      (spi_rsp),
        .frame_active (frame_active),
        .data_req     (data_req),
        .prog_data    (prog_data),
        .flash_id     (flash_id),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .done         (done),
        .error        (error)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s, %s: expected 0x%0h, actual 0x%0h",
                     test_name, name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR %s: %s", test_name, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // Three ID bytes returned by the frame starting at row first
    function automatic logic [23:0] expected_id(input int first);
        return {XFER_TABLE[first + 1].rx, XFER_TABLE[first + 2].rx, XFER_TABLE[first + 3].rx};
    endfunction

    task automatic check_idle(input string when);
        check_value({when, ", transfer enable"}, 1'b0, spi_req.en);
        check_value({when, ", frame_active"}, 1'b0, frame_active);
        check_value({when, ", data_req"}, 1'b0, data_req);
        check_value({when, ", rd_valid"}, 1'b0, rd_valid);
        check_value({when, ", done"}, 1'b0, done);
        check_value({when, ", error"}, 1'b0, error);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_dut();
        int i;
        rst_n     <= 1'b0;
        spi_rsp   <= '0;
        prog_data <= PAGE_DATA[0];      // First byte ready before the sequence starts
        wr_cnt    = 0;
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_idle("during reset");
            end
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_idle("after reset");
    endtask

    task automatic wait_enable();
        int n;
        n = 0;
        @(posedge clk);
        while (!spi_req.en && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!spi_req.en) begin
            report_failure("timed out waiting for a transfer enable");
        end
    endtask

    task automatic wait_end_flag(input logic want_error);
        int n;
        n = 0;
        @(posedge clk);
        while (!(want_error ? error : done) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!(want_error ? error : done)) begin
            report_failure(want_error ? "error flag never rose" : "done flag never rose");
        end
    endtask

    // Serializer model, one table row per byte transfer
    task automatic play_rows(input int first, input int count);
        xfer_row_t row;
        int        delay;
        int        i;
        for (i = first; i < first + count; i++) begin
            row = XFER_TABLE[i];
            wait_enable();
            check_value("transmit byte", row.tx, spi_req.tx_byte);
            check_value("frame_active at enable", 1'b1, frame_active);
            if (data_req && wr_cnt >= `PAGE_BYTES) begin
                report_failure("more data_req pulses than page bytes");
            end else if (data_req) begin
                check_value("page program byte", PAGE_DATA[wr_cnt], spi_req.tx_byte);
                wr_cnt++;
                if (wr_cnt < `PAGE_BYTES) begin
                    prog_data <= PAGE_DATA[wr_cnt];
                end
            end
            delay = 1 + ({$random(seed)} % 4);
            repeat (delay - 1) @(posedge clk);
            spi_rsp <= '{done: 1'b1, rx_byte: row.rx};
            @(posedge clk);
            spi_rsp <= '0;
            @(posedge clk);
            check_value("frame_active after transfer", !row.eof, frame_active);
        end
    endtask

    // Readback stream against the page contents
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_cnt <= 0;
        end else if (rd_valid && rd_cnt >= `PAGE_BYTES) begin
            report_failure("more rd_valid pulses than page bytes");
        end else if (rd_valid) begin
            check_value("readback byte", PAGE_DATA[rd_cnt], rd_data);
            rd_cnt <= rd_cnt + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Runs
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        seed      = 22691;
        test_name = "good ID run";
        reset_dut();
        play_rows(GOOD_FIRST, ID_ROWS);
        check_value("flash_id", expected_id(GOOD_FIRST), flash_id);
        play_rows(GOOD_FIRST + ID_ROWS, GOOD_ROWS - ID_ROWS);
        wait_end_flag(1'b0);
        check_value("error at done", 1'b0, error);
        check_value("data_req count", `PAGE_BYTES, wr_cnt);
        check_value("rd_valid count", `PAGE_BYTES, rd_cnt);

        test_name = "bad ID run";
        reset_dut();
        play_rows(BAD_FIRST, BAD_ROWS);
        check_value("flash_id", expected_id(BAD_FIRST), flash_id);
        wait_end_flag(1'b1);
        check_value("done at error", 1'b0, done);
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            check_value("enable after error", 1'b0, spi_req.en);
            check_value("frame_active after error", 1'b0, frame_active);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule
